/* common/decodePkg.sv */
// =========================================================================
// Shared types and constants for the register-operand decode stage.
// Only the first source and the destination register fields are described.
// Opcode encodings are local to this core and occupy instruction bits 6:0.
// Register numbers 72 and up are reserved and must raise an exception.
// =========================================================================

package decodePkg;

	// =========================================================================
	// Widths that carry a meaning
	// =========================================================================

	// Raw 32-bit instruction word as fetched
	typedef logic [31:0] instrWord;

	// Micro-op is {xRd, xRs1, instrWord}, the x fields widen 5-bit fields to 7
	typedef logic [35:0] microOp;

	// Architectural register number before mapping
	typedef logic [6:0] aregNo;

	// Mapped register number, one bit wider to hold the banked stack pointers
	typedef logic [7:0] mregNo;

	// Privilege level the core is running at
	typedef enum logic [1:0]
	{
		modeUser       = 2'd0,
		modeSupervisor = 2'd1,
		modeHypervisor = 2'd2,
		modeMachine    = 2'd3
	} operatingMode;

	// Primary opcode field
	typedef enum logic [6:0]
	{
		opAdd    = 7'h04,
		opSub    = 7'h05,
		opAnd    = 7'h08,
		opOr     = 7'h09,
		opXor    = 7'h0A,
		opMov    = 7'h10,
		opFlt    = 7'h20,
		opBranch = 7'h30,
		opLoad   = 7'h40,
		opStore  = 7'h48,
		opPush   = 7'h50,
		opPop    = 7'h51
	} opcode;

	// =========================================================================
	// Field positions
	// =========================================================================

	// Extension fields in the upper bits of the micro-op
	localparam int uopXRdHi  = 35;
	localparam int uopXRdLo  = 34;
	localparam int uopXRs1Hi = 33;
	localparam int uopXRs1Lo = 32;

	// Opcode sits at the bottom of every format
	localparam int opcodeHi = 6;
	localparam int opcodeLo = 0;

	// Destination and first source register fields
	localparam int rdHi  = 11;
	localparam int rdLo  = 7;
	localparam int rs1Hi = 16;
	localparam int rs1Lo = 12;

	// Branch register select overlaps the low Rs1 bits in branch formats
	localparam int brsHi = 14;
	localparam int brsLo = 12;

	// Move format: sub-operation, high source bits and target mode
	localparam int movSubopHi = 31;
	localparam int movSubopLo = 29;
	localparam int movRs1Hi   = 23;
	localparam int movRs1Lo   = 22;
	localparam int movModeHi  = 25;
	localparam int movModeLo  = 24;

	// =========================================================================
	// Register map limits
	// =========================================================================

	// Stack pointer, banked per operating mode
	localparam aregNo spReg = 7'd31;

	// Start of the float and branch/link register ranges
	localparam aregNo floatBase  = 7'd32;
	localparam aregNo branchBase = 7'd64;

	// Everything from here up is reserved
	localparam aregNo firstReserved = 7'd72;

	// Banked stack pointers live at bankBase plus the mode index
	localparam mregNo bankBase = 8'd96;

	// Move sub-operation that names its own operating mode
	localparam logic [2:0] subopMoveMode = 3'd1;

endpackage

/* decode/regMapper.sv */
// =========================================================================
// Architectural to mapped register number, purely combinational.
// Only the stack pointer is banked, all other legal numbers pass through.
// Reserved numbers give a mapped value of 0 with exc set.
// =========================================================================

`timescale 1ns/100ps

module regMapper
(
	input  decodePkg::aregNo        areg,
	input  decodePkg::operatingMode mode,
	output decodePkg::mregNo        mreg,
	output logic                    exc
);

	import decodePkg::*;

	// Banked slot for the stack pointer in the requested mode
	mregNo bankedSp;

	assign bankedSp = bankBase + {6'd0, mode};

	always_comb
	begin
		// Default is a plain pass-through, widened by one bit
		mreg = {1'b0, areg};
		exc  = 1'b0;

		if (areg >= firstReserved)
		begin
			// Reserved range, the value must not be used downstream
			mreg = '0;
			exc  = 1'b1;
		end
		else if (areg == spReg)
		begin
			mreg = bankedSp;
		end
	end

endmodule

/* decode/decodeRs1.sv */
// =========================================================================
// First source register decode.
// An immediate in the first operand slot forces the source to register 0.
// Move-to-mode maps its source in the mode carried by the instruction.
// =========================================================================

`timescale 1ns/100ps

module decodeRs1
(
	input  decodePkg::microOp       uop,
	input  decodePkg::operatingMode mode,
	input  logic                    hasImma,
	output decodePkg::mregNo        rs1,
	output logic                    rs1Zero,
	output logic                    exc
);

	import decodePkg::*;

	instrWord     ir;
	opcode        op;
	logic [2:0]   subop;
	logic [2:0]   brs;
	logic [4:0]   rs1Fld;
	logic [1:0]   xRs1;
	logic [1:0]   movHi;
	aregNo        srcReg;
	operatingMode effMode;

	// Field extraction
	assign ir     = uop[31:0];
	assign op     = opcode'(ir[opcodeHi:opcodeLo]);
	assign subop  = ir[movSubopHi:movSubopLo];
	assign brs    = ir[brsHi:brsLo];
	assign rs1Fld = ir[rs1Hi:rs1Lo];
	assign xRs1   = uop[uopXRs1Hi:uopXRs1Lo];
	assign movHi  = ir[movRs1Hi:movRs1Lo];

	// =========================================================================
	// Architectural source number
	// =========================================================================

	always_comb
	begin
		if (hasImma)
			srcReg = '0;
		else
			case (op)
			opAdd, opSub, opAnd, opOr, opXor, opLoad, opStore:
				srcReg = {xRs1, rs1Fld};
			opFlt:
				srcReg = floatBase + {2'b00, rs1Fld};
			opMov:
				// Lower sub-operations can reach the full 7-bit register space
				if (subop < 3'd4)
					srcReg = {movHi, rs1Fld};
				else
					srcReg = {2'b00, rs1Fld};
			opBranch:
				// BRs of zero means no branch register is read
				srcReg = (brs == 3'd0) ? '0 : branchBase + {4'b0000, brs};
			opPush, opPop:
				srcReg = '0;
			default:
				srcReg = '0;
			endcase
	end

	// Move-to-mode reads the source as seen from the target mode
	always_comb
	begin
		if (op == opMov && subop == subopMoveMode)
			effMode = operatingMode'(ir[movModeHi:movModeLo]);
		else
			effMode = mode;
	end

	// Zero flag reflects the architectural number, before banking
	assign rs1Zero = (srcReg == '0);

	regMapper mapper
	(
		.areg (srcReg),
		.mode (effMode),
		.mreg (rs1),
		.exc  (exc)
	);

endmodule

/* decode/decodeRd.sv */
// =========================================================================
// Destination register decode.
// The destination is always mapped in the current mode, move-to-mode only
// affects the source side.
// =========================================================================

`timescale 1ns/100ps

module decodeRd
(
	input  decodePkg::microOp       uop,
	input  decodePkg::operatingMode mode,
	output decodePkg::mregNo        rd,
	output logic                    exc
);

	import decodePkg::*;

	opcode      op;
	logic [4:0] rdFld;
	logic [1:0] xRd;
	aregNo      dstReg;

	assign op    = opcode'(uop[opcodeHi:opcodeLo]);
	assign rdFld = uop[rdHi:rdLo];
	assign xRd   = uop[uopXRdHi:uopXRdLo];

	// Stores, branches, push and pop write no register here
	always_comb
	begin
		case (op)
		opAdd, opSub, opAnd, opOr, opXor, opLoad, opMov:
			dstReg = {xRd, rdFld};
		opFlt:
			dstReg = floatBase + {2'b00, rdFld};
		default:
			dstReg = '0;
		endcase
	end

	regMapper mapper
	(
		.areg (dstReg),
		.mode (mode),
		.mreg (rd),
		.exc  (exc)
	);

endmodule

/* hdl/decodeStage.sv */
// =========================================================================
// Register-operand decode stage with one cycle of latency.
// A micro-op is accepted every cycle, there is no stall or back-pressure.
// Data outputs hold their last value while inValid is low.
// =========================================================================

`timescale 1ns/100ps

module decodeStage
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    inValid,
	input  decodePkg::operatingMode mode,
	input  decodePkg::microOp       uop,
	input  logic                    hasImma,
	output logic                    outValid,
	output decodePkg::mregNo        rs1,
	output logic                    rs1Zero,
	output logic                    rs1Exc,
	output decodePkg::mregNo        rd,
	output logic                    rdExc
);

	import decodePkg::*;

	// Combinational decoder results
	mregNo rs1Next;
	logic  rs1ZeroNext;
	logic  rs1ExcNext;
	mregNo rdNext;
	logic  rdExcNext;

	// =========================================================================
	// Decoders
	// =========================================================================

	decodeRs1 uRs1
	(
		.uop     (uop),
		.mode    (mode),
		.hasImma (hasImma),
		.rs1     (rs1Next),
		.rs1Zero (rs1ZeroNext),
		.exc     (rs1ExcNext)
	);

	decodeRd uRd
	(
		.uop  (uop),
		.mode (mode),
		.rd   (rdNext),
		.exc  (rdExcNext)
	);

	// =========================================================================
	// Output register
	// =========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			outValid <= 1'b0;
			rs1      <= '0;
			rs1Zero  <= 1'b0;
			rs1Exc   <= 1'b0;
			rd       <= '0;
			rdExc    <= 1'b0;
		end
		else
		begin
			// Valid is a plain strobe, it drops the cycle after an idle input
			outValid <= inValid;
			if (inValid)
			begin
				rs1     <= rs1Next;
				rs1Zero <= rs1ZeroNext;
				rs1Exc  <= rs1ExcNext;
				rd      <= rdNext;
				rdExc   <= rdExcNext;
			end
		end
	end

endmodule

/* tests/decodeStage_assertions.sv */
// ==========================================================================
// Concurrent checks on the decode stage outputs, bound into decodeStage.
// Valid timing is only checked while reset is low.
// ==========================================================================

`timescale 1ns/100ps

module decodeStageAssertions
(
	input logic             clk,
	input logic             rst,
	input logic             inValid,
	input logic             outValid,
	input decodePkg::mregNo rs1,
	input logic             rs1Exc,
	input decodePkg::mregNo rd,
	input logic             rdExc
);

	// outValid is inValid delayed by exactly one edge
	validFollowsInput: assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> (outValid == $past(inValid)))
		else $error("outValid does not follow inValid by one cycle");

	// The register is cleared on the reset edge
	validLowAfterReset: assert property (@(posedge clk) rst |=> !outValid)
		else $error("outValid is high in the cycle after reset");

	// Reserved numbers never leak a mapped value
	rs1ExcZero: assert property (@(posedge clk) rs1Exc |-> (rs1 == '0))
		else $error("rs1Exc is set with a nonzero rs1");

	rdExcZero: assert property (@(posedge clk) rdExc |-> (rd == '0))
		else $error("rdExc is set with a nonzero rd");

endmodule

bind decodeStage decodeStageAssertions sva
(
	.clk      (clk),
	.rst      (rst),
	.inValid  (inValid),
	.outValid (outValid),
	.rs1      (rs1),
	.rs1Exc   (rs1Exc),
	.rd       (rd),
	.rdExc    (rdExc)
);

/* tests/decodeStageTb.sv */
// ==========================================================================
// Testbench for the register-operand decode stage.
// Cases come from tests/decode_cases.txt, one micro-op per line, in hex.
// Idle gaps of 0 to 3 cycles come from an xorshift generator seeded with 16.
// The run stops at the first mismatch or timeout.
// ==========================================================================

`timescale 1ns/100ps

module decodeStageTb;

	import decodePkg::*;

	localparam int  resetCycles  = 10;
	localparam int  validTimeout = 20;
	localparam time driveDelay   = 1;

	// An opAdd whose source and destination both decode to reserved register 127
	localparam microOp idleUop = 36'hF0001FF84;

	// DUT inputs
	logic         clk;
	logic         rst;
	logic         inValid;
	operatingMode mode;
	microOp       uop;
	logic         hasImma;

	// DUT outputs
	logic         outValid;
	mregNo        rs1;
	logic         rs1Zero;
	logic         rs1Exc;
	mregNo        rd;
	logic         rdExc;

	// Running case number for error lines
	int           caseNo;
	logic [31:0]  rngState;

	decodeStage dut
	(
		.clk      (clk),
		.rst      (rst),
		.inValid  (inValid),
		.mode     (mode),
		.uop      (uop),
		.hasImma  (hasImma),
		.outValid (outValid),
		.rs1      (rs1),
		.rs1Zero  (rs1Zero),
		.rs1Exc   (rs1Exc),
		.rd       (rd),
		.rdExc    (rdExc)
	);

	// 10 ns clock
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==========================================================================
	// Helpers
	// ==========================================================================

	// One 32-bit xorshift step with shifts of 13, 17 and 5
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic failRun();
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkMreg(input string what, input mregNo got, input mregNo exp);
		if (got !== exp)
		begin
			$display("** Error at %0t ns: case %0d, %s is %02h, expected %02h",
				$time, caseNo, what, got, exp);
			failRun();
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error at %0t ns: case %0d, %s is %b, expected %b",
				$time, caseNo, what, got, exp);
			failRun();
		end
	endtask

	// Inputs change a little after the rising edge while the outputs are stable
	task automatic nextEdge();
		@(posedge clk);
		#driveDelay;
	endtask

	// Runs one line of the case file through an idle gap, the drive and the compare
	task automatic runCase(input string line);
		int         fields;
		int         idle;
		int         cycles;
		logic [3:0] modeVal;
		logic [35:0] uopVal;
		logic       immVal;
		mregNo      expRs1;
		logic       expZero;
		logic       expRs1Exc;
		mregNo      expRd;
		logic       expRdExc;
		mregNo      heldRs1;
		logic       heldZero;
		logic       heldRs1Exc;
		mregNo      heldRd;
		logic       heldRdExc;

		fields = $sscanf(line, "%h %h %h %h %h %h %h %h", modeVal, uopVal, immVal,
			expRs1, expZero, expRs1Exc, expRd, expRdExc);
		if (fields != 8)
		begin
			$display("A line of the case file could not be parsed: %s", line);
			failRun();
		end
		caseNo++;

		// Idle cycles must drop outValid and leave the data registers alone
		rngState   = xorshift32(rngState);
		idle       = rngState % 4;
		heldRs1    = rs1;
		heldZero   = rs1Zero;
		heldRs1Exc = rs1Exc;
		heldRd     = rd;
		heldRdExc  = rdExc;

		// The idle micro-op would set both exception flags if it were loaded
		inValid = 1'b0;
		uop     = idleUop;
		hasImma = 1'b0;
		repeat (idle)
		begin
			nextEdge();
			checkFlag("outValid while idle", outValid, 1'b0);
			checkMreg("rs1 held while idle", rs1, heldRs1);
			checkFlag("rs1Zero held while idle", rs1Zero, heldZero);
			checkFlag("rs1Exc held while idle", rs1Exc, heldRs1Exc);
			checkMreg("rd held while idle", rd, heldRd);
			checkFlag("rdExc held while idle", rdExc, heldRdExc);
		end

		mode    = operatingMode'(modeVal[1:0]);
		uop     = uopVal;
		hasImma = immVal;
		inValid = 1'b1;

		// Count edges until the result shows up as the stage should need only one
		cycles = 0;
		do
		begin
			nextEdge();
			inValid = 1'b0;
			cycles++;
		end
		while (!outValid && cycles < validTimeout);

		if (!outValid)
		begin
			$display("Timeout: outValid did not rise within %0d cycles for case %0d",
				validTimeout, caseNo);
			failRun();
		end
		if (cycles != 1)
		begin
			$display("** Error at %0t ns: case %0d, result took %0d cycles, expected 1",
				$time, caseNo, cycles);
			failRun();
		end

		checkMreg("rs1", rs1, expRs1);
		checkFlag("rs1Zero", rs1Zero, expZero);
		checkFlag("rs1Exc", rs1Exc, expRs1Exc);
		checkMreg("rd", rd, expRd);
		checkFlag("rdExc", rdExc, expRdExc);
	endtask

	// ==========================================================================
	// Main sequence
	// ==========================================================================

	initial
	begin
		int    fd;
		int    got;
		string line;

		rst      = 1'b1;
		inValid  = 1'b0;
		mode     = modeUser;
		uop      = '0;
		hasImma  = 1'b0;
		caseNo   = 0;
		rngState = 32'd16;

		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		rst = 1'b0;

		// Everything is cleared by reset
		checkFlag("outValid after reset", outValid, 1'b0);
		checkFlag("rs1Exc after reset", rs1Exc, 1'b0);
		checkFlag("rdExc after reset", rdExc, 1'b0);
		checkMreg("rs1 after reset", rs1, 8'h00);
		checkMreg("rd after reset", rd, 8'h00);

		fd = $fopen("tests/decode_cases.txt", "r");
		if (fd == 0)
		begin
			$display("The case file tests/decode_cases.txt could not be opened");
			failRun();
		end

		// Lines starting with a slash are comments
		while (!$feof(fd))
		begin
			line = "";
			got  = $fgets(line, fd);
			if (got > 0 && line.len() > 1 && line.getc(0) != "/")
				runCase(line);
		end
		$fclose(fd);

		if (caseNo == 0)
		begin
			$display("No cases were read from the case file");
			failRun();
		end
		else
		begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

/* tests/decode_cases.txt */
// Columns, all hex: mode uop(36 bit) hasImma | rs1 rs1Zero rs1Exc rd rdExc
// uop is {xRd, xRs1, instrWord}, so the first uop digit holds xRd and xRs1
0 000005184 0 05 0 0 03 0
1 500002385 0 22 0 0 27 0
2 200003208 0 43 0 0 04 0
3 000011A09 0 11 0 0 14 0
0 00000000A 0 00 1 0 00 0
1 4000084C0 0 08 0 0 29 0
2 D00006FC8 0 26 0 0 00 0
0 000005184 1 00 1 0 03 0
3 30001F540 1 00 1 0 0A 0
0 00001FF84 0 60 0 0 60 0
1 00001FF84 0 61 0 0 61 0
2 00001FF84 0 62 0 0 62 0
3 00001FF84 0 63 0 0 63 0
3 00001FF40 0 63 0 0 1E 0
1 00001F148 0 61 0 0 00 0
0 000001F8A 0 01 0 0 60 0
2 50001FF88 0 3F 0 0 3F 0
0 000000020 0 20 0 0 20 0
1 00001FFA0 0 3F 0 0 3F 0
2 F0000AAA0 0 2A 0 0 35 0
0 000005620 1 00 1 0 2C 0
0 000018030 0 00 1 0 00 0
0 0000012B0 0 41 0 0 00 0
3 000007030 0 47 0 0 00 0
2 00001C030 0 44 0 0 00 0
1 000003030 1 00 1 0 00 0
0 5000053D0 0 00 1 0 00 0
1 00001FFD1 0 00 1 0 00 0
2 00001FFFF 0 00 1 0 00 0
0 30001F006 0 00 1 0 00 0
0 30001F084 0 00 0 1 01 0
1 E00008005 0 00 0 1 00 1
2 A00007408 0 47 0 0 00 1
3 C00002FC0 0 02 0 0 00 1
0 F00000048 0 00 0 1 00 0
1 A0001F389 0 00 0 1 47 0
2 000C1F190 0 00 0 1 03 0
0 C40405410 0 25 0 0 00 1
0 02301FF90 0 63 0 0 60 0
3 02001FF90 0 60 0 0 63 0
1 02201FF90 0 62 0 0 61 0
0 022405310 0 25 0 0 06 0
1 00301FF90 0 61 0 0 61 0
2 083C1F110 0 62 0 0 02 0
3 4E080A790 0 0A 0 0 2F 0
0 02301FF90 1 00 1 0 60 0
0 02181F090 0 00 0 1 01 0
1 060800010 0 40 0 0 00 0

/* compile.f */
common/decodePkg.sv
decode/regMapper.sv
decode/decodeRs1.sv
decode/decodeRd.sv
hdl/decodeStage.sv
tests/decodeStage_assertions.sv
tests/decodeStageTb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - common/decodePkg.sv
  - decode/regMapper.sv
  - decode/decodeRs1.sv
  - decode/decodeRd.sv
  - hdl/decodeStage.sv
  - target: test
    files:
      - tests/decodeStage_assertions.sv
      - tests/decodeStageTb.sv
